// ==== logic/fetch_pc_pkg.sv ====
`default_nettype none

package fetch_pc_pkg;

    localparam int XLEN  = 64;
    localparam int SLOTS = 4;  // 32-bit slots in one 16-byte fetch block

    // major opcode field, inst[6:2]
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;

    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_JAL    = 2'd1,
        CF_JALR   = 2'd2,
        CF_BRANCH = 2'd3
    } slot_kind_e;

    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_RESET = 2'b01;  // weakly not taken

endpackage

`default_nettype wire

// ==== logic/predecode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface predecode_if import fetch_pc_pkg::*; ();

    logic            cf_valid;    // a control-flow slot was found at or after the pc
    slot_kind_e      cf_kind;
    logic [1:0]      cf_slot;
    logic [XLEN-1:0] cf_imm;      // byte offset, already sign extended
    logic [4:0]      cf_rs1;
    logic [1:0]      start_slot;

    modport src (
        output cf_valid, cf_kind, cf_slot, cf_imm, cf_rs1, start_slot
    );

    modport ctl (
        input cf_valid, cf_kind, cf_slot, start_slot
    );

    modport tgt (
        input cf_kind, cf_imm
    );

endinterface

`default_nettype wire

// ==== logic/packet_predecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module packet_predecode
    import fetch_pc_pkg::*;
(
    input  logic [1:0]          i_pc_slot,
    input  logic [32*SLOTS-1:0] i_inst_packet,
    predecode_if.src            pd,
    output logic                o_jreg_ena,
    output logic [4:0]          o_jreg_addr
);

    logic [31:0] slot_inst [SLOTS];
    slot_kind_e  slot_kind [SLOTS];
    logic [31:0] sel_inst;

    function automatic slot_kind_e classify(input logic [31:0] inst);
        slot_kind_e kind;
        kind = CF_NONE;
        if (inst[1:0] == 2'b11) begin  // 16-bit encodings never match
            case (inst[6:2])
                OPC_JAL:    kind = CF_JAL;
                OPC_JALR:   kind = CF_JALR;
                OPC_BRANCH: kind = CF_BRANCH;
                default:    kind = CF_NONE;
            endcase
        end
        return kind;
    endfunction

    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            slot_inst[s] = i_inst_packet[32*s +: 32];
            slot_kind[s] = classify(slot_inst[s]);
        end
    end

    // scanning from the top down leaves the lowest eligible slot selected
    always_comb begin
        pd.cf_valid = 1'b0;
        pd.cf_slot  = 2'd0;
        for (int s = SLOTS - 1; s >= 0; s--) begin
            if (s >= int'(i_pc_slot) && slot_kind[s] != CF_NONE) begin
                pd.cf_valid = 1'b1;
                pd.cf_slot  = 2'(s);
            end
        end
    end

    assign pd.start_slot = i_pc_slot;
    assign sel_inst      = slot_inst[pd.cf_slot];
    assign pd.cf_kind    = pd.cf_valid ? slot_kind[pd.cf_slot] : CF_NONE;
    assign pd.cf_rs1     = sel_inst[19:15];

    always_comb begin
        case (pd.cf_kind)
            CF_JAL: begin
                pd.cf_imm = {{(XLEN-20){sel_inst[31]}}, sel_inst[19:12],
                             sel_inst[20], sel_inst[30:21], 1'b0};
            end
            CF_BRANCH: begin
                pd.cf_imm = {{(XLEN-12){sel_inst[31]}}, sel_inst[7],
                             sel_inst[30:25], sel_inst[11:8], 1'b0};
            end
            CF_JALR: pd.cf_imm = {{(XLEN-12){sel_inst[31]}}, sel_inst[31:20]};
            default: pd.cf_imm = '0;
        endcase
    end

    assign o_jreg_ena  = (pd.cf_kind == CF_JALR);
    assign o_jreg_addr = o_jreg_ena ? pd.cf_rs1 : 5'd0;  // register file sees x0 when idle

endmodule

`default_nettype wire

// ==== logic/branch_history_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module branch_history_table
    import fetch_pc_pkg::*;
#(
    parameter int PHT_DEPTH = 16
)
(
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic [$clog2(PHT_DEPTH)-1:0] i_rd_index,
    output logic                         o_rd_taken,
    input  logic                         i_upd_valid,
    input  logic [$clog2(PHT_DEPTH)-1:0] i_upd_index,
    input  logic                         i_upd_taken
);

    ctr_t ctr [PHT_DEPTH];
    ctr_t upd_ctr;

    assign upd_ctr = ctr[i_upd_index];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int e = 0; e < PHT_DEPTH; e++) begin
                ctr[e] <= CTR_RESET;
            end
        end else if (i_upd_valid) begin
            if (i_upd_taken && upd_ctr != 2'b11) begin
                ctr[i_upd_index] <= upd_ctr + 2'd1;
            end else if (!i_upd_taken && upd_ctr != 2'b00) begin
                ctr[i_upd_index] <= upd_ctr - 2'd1;  // saturates at strongly not taken
            end
        end
    end

    // read is combinational, so an update only shows on the following cycle
    assign o_rd_taken = (ctr[i_rd_index] >= 2'd2);

endmodule

`default_nettype wire

// ==== logic/jump_target_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module jump_target_unit
    import fetch_pc_pkg::*;
(
    input  logic [XLEN-1:0] i_slot_pc,
    input  logic [XLEN-1:0] i_jreg_data,
    predecode_if.tgt        tg,
    output logic [XLEN-1:0] o_target
);

    logic            is_jalr;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;

    assign is_jalr = (tg.cf_kind == CF_JALR);

    // jal and branches are pc relative, jalr is register relative
    assign base = is_jalr ? i_jreg_data : i_slot_pc;
    assign sum  = base + tg.cf_imm;

    always_comb begin
        if (is_jalr) begin
            o_target = {sum[XLEN-1:1], 1'b0};  // jalr drops the low bit of the sum
        end else begin
            o_target = sum;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pc_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_control
    import fetch_pc_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC  = 64'h8000_0000,
    parameter int              PHT_DEPTH = 16
)
(
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_fetch_stall,
    input  logic                         i_dec1_redirect,
    input  logic [XLEN-1:0]              i_dec1_pc,
    input  logic                         i_dec2_redirect,
    input  logic [XLEN-1:0]              i_dec2_pc,
    input  logic                         i_trap,
    input  logic [XLEN-1:0]              i_trap_pc,
    predecode_if.ctl                     pd,
    input  logic                         i_bht_taken,
    input  logic [XLEN-1:0]              i_target,
    output logic [$clog2(PHT_DEPTH)-1:0] o_bht_index,
    output logic [XLEN-1:0]              o_slot_pc,
    output logic [XLEN-1:0]              o_pc,
    output logic [2:0]                   o_pc_count,
    output logic                         o_pc_ready
);

    localparam int IDX_W = $clog2(PHT_DEPTH);

    logic [XLEN-1:0] block_base;
    logic            take_jump;
    logic [2:0]      count_next;
    logic            redir_valid;
    logic [XLEN-1:0] redir_pc;
    logic            pend_valid;
    logic [XLEN-1:0] pend_pc;
    logic [XLEN-1:0] pc_next;

    assign block_base  = {o_pc[XLEN-1:4], 4'b0000};
    assign o_slot_pc   = {o_pc[XLEN-1:4], pd.cf_slot, 2'b00};
    assign o_bht_index = o_slot_pc[IDX_W+1:2];

    // jal and jalr always jump, a branch only when its counter says taken
    assign take_jump = pd.cf_valid && (pd.cf_kind != CF_BRANCH || i_bht_taken);

    assign count_next = take_jump ? ({1'b0, pd.cf_slot} - {1'b0, pd.start_slot} + 3'd1)
                                  : (3'd4 - {1'b0, pd.start_slot});

    assign redir_valid = i_dec1_redirect || i_dec2_redirect || i_trap;

    always_comb begin
        if (i_dec1_redirect) begin
            redir_pc = i_dec1_pc;
        end else if (i_dec2_redirect) begin
            redir_pc = i_dec2_pc;
        end else begin
            redir_pc = i_trap_pc;
        end
    end

    always_comb begin
        if (redir_valid) begin
            pc_next = redir_pc;
        end else if (pend_valid) begin
            pc_next = pend_pc;  // redirect that came in while stalled
        end else if (take_jump) begin
            pc_next = i_target;
        end else begin
            pc_next = block_base + XLEN'(16);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_pc       <= RESET_PC;
            o_pc_count <= 3'd4;
        end else if (!i_fetch_stall) begin
            o_pc       <= pc_next;
            o_pc_count <= count_next;
        end
    end

    // newest redirect of a stall wins, cleared on the first free edge
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pend_valid <= 1'b0;
        end else if (!i_fetch_stall) begin
            pend_valid <= 1'b0;
        end else if (redir_valid) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetch_stall && redir_valid) begin
            pend_pc <= redir_pc;
        end
    end

    assign o_pc_ready = !i_rst;

endmodule

`default_nettype wire

// ==== logic/fetch_pc_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_top
    import fetch_pc_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC  = 64'h8000_0000,
    parameter int              PHT_DEPTH = 16
)
(
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic [32*SLOTS-1:0]          i_inst_packet,
    output logic                         o_jreg_ena,
    output logic [4:0]                   o_jreg_addr,
    input  logic [XLEN-1:0]              i_jreg_data,
    input  logic                         i_dec1_redirect,
    input  logic [XLEN-1:0]              i_dec1_pc,
    input  logic                         i_dec2_redirect,
    input  logic [XLEN-1:0]              i_dec2_pc,
    input  logic                         i_trap,
    input  logic [XLEN-1:0]              i_trap_pc,
    input  logic                         i_bru_valid,
    input  logic [$clog2(PHT_DEPTH)-1:0] i_bru_index,
    input  logic                         i_bru_taken,
    input  logic                         i_fetch_stall,
    output logic [XLEN-1:0]              o_pc,
    output logic [2:0]                   o_pc_count,
    output logic                         o_pc_ready
);

    logic [$clog2(PHT_DEPTH)-1:0] bht_index;
    logic                         bht_taken;
    logic [XLEN-1:0]              slot_pc;
    logic [XLEN-1:0]              target;

    predecode_if pd_bus ();

    packet_predecode u_predecode (
        .i_pc_slot     (o_pc[3:2]),
        .i_inst_packet (i_inst_packet),
        .pd            (pd_bus),
        .o_jreg_ena    (o_jreg_ena),
        .o_jreg_addr   (o_jreg_addr)
    );

    branch_history_table #(
        .PHT_DEPTH (PHT_DEPTH)
    ) u_bht (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_rd_index  (bht_index),
        .o_rd_taken  (bht_taken),
        .i_upd_valid (i_bru_valid),
        .i_upd_index (i_bru_index),
        .i_upd_taken (i_bru_taken)
    );

    jump_target_unit u_target (
        .i_slot_pc   (slot_pc),
        .i_jreg_data (i_jreg_data),
        .tg          (pd_bus),
        .o_target    (target)
    );

    pc_control #(
        .RESET_PC  (RESET_PC),
        .PHT_DEPTH (PHT_DEPTH)
    ) u_pc_control (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_fetch_stall   (i_fetch_stall),
        .i_dec1_redirect (i_dec1_redirect),
        .i_dec1_pc       (i_dec1_pc),
        .i_dec2_redirect (i_dec2_redirect),
        .i_dec2_pc       (i_dec2_pc),
        .i_trap          (i_trap),
        .i_trap_pc       (i_trap_pc),
        .pd              (pd_bus),
        .i_bht_taken     (bht_taken),
        .i_target        (target),
        .o_bht_index     (bht_index),
        .o_slot_pc       (slot_pc),
        .o_pc            (o_pc),
        .o_pc_count      (o_pc_count),
        .o_pc_ready      (o_pc_ready)
    );

endmodule

`default_nettype wire

// ==== testbench/fetch_pc_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_asserts
    import fetch_pc_pkg::*;
(
    input wire logic            clk,
    input wire logic            i_rst,
    input wire logic            i_fetch_stall,
    input wire logic [XLEN-1:0] o_pc,
    input wire logic [2:0]      o_pc_count
);

    int fail_count = 0;

    stall_holds_pc: assert property (@(posedge clk) disable iff (i_rst)
        i_fetch_stall |=> $stable(o_pc))
        else begin
            $error("pc moved during a stall");
            fail_count++;
        end

    pc_word_aligned: assert property (@(posedge clk) disable iff (i_rst)
        o_pc[1:0] == 2'b00)
        else begin
            $error("pc is not a multiple of 4");
            fail_count++;
        end

    count_in_range: assert property (@(posedge clk) disable iff (i_rst)
        o_pc_count >= 3'd1 && o_pc_count <= 3'd4)
        else begin
            $error("slot count out of range");
            fail_count++;
        end

endmodule

bind pc_control fetch_pc_asserts u_asserts (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_fetch_stall (i_fetch_stall),
    .o_pc          (o_pc),
    .o_pc_count    (o_pc_count)
);

`default_nettype wire

// ==== testbench/fetch_pc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_tb
    import fetch_pc_pkg::*;
();

    localparam logic [63:0] RESET_PC   = 64'h8000_0000;
    localparam int          MAX_CYCLES = 2000;  // the tests take about 600 cycles
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic         clk = 1'b0;
    logic         i_rst, i_fetch_stall, i_dec1_redirect, i_dec2_redirect, i_trap;
    logic         i_bru_valid, i_bru_taken, o_jreg_ena, o_pc_ready;
    logic [3:0]   i_bru_index;
    logic [4:0]   o_jreg_addr;
    logic [2:0]   o_pc_count, exp_cnt;
    logic [63:0]  i_dec1_pc, i_dec2_pc, i_trap_pc, i_jreg_data, o_pc, exp_pc, pend_pc;
    logic [127:0] i_inst_packet, fixed_pkt;
    logic [1:0]   pkt_mode;  // 0 straight-line code, 1 fixed packet, 2 hashed random
    logic [31:0]  salt, rnd;
    logic         pend_v;
    logic [1:0]   shadow_ctr [16];
    int           err_count, err_mark, test_count, cycles;

    fetch_pc_top #(.RESET_PC(RESET_PC), .PHT_DEPTH(16)) dut0 (
        .clk(clk), .i_rst(i_rst), .i_inst_packet(i_inst_packet), .o_jreg_ena(o_jreg_ena),
        .o_jreg_addr(o_jreg_addr), .i_jreg_data(i_jreg_data),
        .i_dec1_redirect(i_dec1_redirect), .i_dec1_pc(i_dec1_pc),
        .i_dec2_redirect(i_dec2_redirect), .i_dec2_pc(i_dec2_pc),
        .i_trap(i_trap), .i_trap_pc(i_trap_pc), .i_bru_valid(i_bru_valid),
        .i_bru_index(i_bru_index), .i_bru_taken(i_bru_taken),
        .i_fetch_stall(i_fetch_stall), .o_pc(o_pc), .o_pc_count(o_pc_count),
        .o_pc_ready(o_pc_ready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [63:0] regval(input logic [4:0] a);
        return (a == 5'd0) ? 64'd0 : 64'h9000_0000 + {a, 6'b0};
    endfunction

    // each slot is hashed from its full address, jump offsets keep word alignment
    function automatic logic [127:0] imem(input logic [63:0] pc, input logic [1:0] mode,
                                          input logic [127:0] fixed, input logic [31:0] sd);
        logic [127:0] pkt;
        logic [63:0]  a;
        logic [31:0]  h;
        for (int s = 0; s < 4; s++) begin
            a = {pc[63:4], 4'(s * 4)};
            h = xorshift(xorshift(a[31:0] ^ a[63:32] ^ sd) + 32'h9e37_79b9);
            case (h[2:0])
                3'd0: pkt[32*s +: 32] = {h[31:22], 1'b0, h[20:7], 7'b1101111};
                3'd1: pkt[32*s +: 32] = {h[31:22], 2'b00, h[19:7], 7'b1100111};
                3'd2, 3'd3: pkt[32*s +: 32] = {h[31:9], 1'b0, h[7], 7'b1100011};
                3'd7: pkt[32*s +: 32] = {h[31:7], 7'b1101101};  // 16-bit encoding
                default: pkt[32*s +: 32] = {h[31:7], 7'b0010011};
            endcase
        end
        return (mode == 2'd0) ? {4{NOP}} : (mode == 2'd1) ? fixed : pkt;
    endfunction

    assign i_inst_packet = imem(o_pc, pkt_mode, fixed_pkt, salt);
    assign i_jreg_data   = regval(o_jreg_addr);

    function automatic void ref_next(input logic [63:0] pc, input logic [127:0] pkt,
                                     output logic [63:0] npc, output logic [2:0] ncnt,
                                     output logic jena, output logic [4:0] jaddr);
        logic [31:0] in;
        logic [63:0] tgt;
        logic [63:0] slot_pc;
        logic        jump;
        jump = 1'b0;
        jena = 1'b0;
        jaddr = 5'd0;
        ncnt = 3'd4 - pc[3:2];
        for (int s = 3; s >= int'(pc[3:2]); s--) begin
            in = pkt[32*s +: 32];
            slot_pc = {pc[63:4], 4'(s * 4)};
            if (in[6:0] == 7'b1101111) begin
                jump = 1'b1;
                jena = 1'b0;
                tgt = slot_pc + {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
            end else if (in[6:0] == 7'b1100111) begin
                jump = 1'b1;
                jena = 1'b1;
                jaddr = in[19:15];
                tgt = (regval(in[19:15]) + {{52{in[31]}}, in[31:20]}) & ~64'd1;
            end else if (in[6:0] == 7'b1100011) begin
                jump = shadow_ctr[slot_pc[5:2]] >= 2'd2;
                jena = 1'b0;
                tgt = slot_pc + {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
            end
            if (in[6:0] == 7'b1101111 || in[6:0] == 7'b1100111 || in[6:0] == 7'b1100011) begin
                // the lowest control-flow slot is visited last
                ncnt = jump ? (3'(s) - {1'b0, pc[3:2]} + 3'd1) : (3'd4 - {1'b0, pc[3:2]});
            end
        end
        if (!jena) begin
            jaddr = 5'd0;
        end
        if (i_dec1_redirect) npc = i_dec1_pc;
        else if (i_dec2_redirect) npc = i_dec2_pc;
        else if (i_trap) npc = i_trap_pc;
        else if (pend_v) npc = pend_pc;
        else if (jump) npc = tgt;
        else npc = {pc[63:4], 4'b0} + 64'd16;
    endfunction

    task automatic report(input string sig, input logic [63:0] exp, input logic [63:0] act);
        $display("ERR %0t %s expected %h actual %h", $time, sig, exp, act);
        err_count++;
    endtask

    always @(negedge clk) begin
        logic [63:0] npc;
        logic [2:0]  ncnt;
        logic        jena;
        logic [4:0]  jaddr;
        if (o_pc !== exp_pc) report("o_pc", exp_pc, o_pc);
        if (o_pc_count !== exp_cnt) report("o_pc_count", 64'(exp_cnt), 64'(o_pc_count));
        if (o_pc_ready !== !i_rst) report("o_pc_ready", 64'(!i_rst), 64'(o_pc_ready));
        ref_next(exp_pc, imem(exp_pc, pkt_mode, fixed_pkt, salt), npc, ncnt, jena, jaddr);
        if (i_rst) begin
            exp_pc = RESET_PC;
            exp_cnt = 3'd4;
            pend_v = 1'b0;
            for (int e = 0; e < 16; e++) shadow_ctr[e] = 2'b01;
        end else begin
            if (o_jreg_ena !== jena) report("o_jreg_ena", 64'(jena), 64'(o_jreg_ena));
            if (o_jreg_addr !== jaddr) report("o_jreg_addr", 64'(jaddr), 64'(o_jreg_addr));
            if (!i_fetch_stall) begin
                exp_pc = npc;
                exp_cnt = ncnt;
                pend_v = 1'b0;
            end else if (i_dec1_redirect || i_dec2_redirect || i_trap) begin
                pend_v = 1'b1;
                pend_pc = i_dec1_redirect ? i_dec1_pc : i_dec2_redirect ? i_dec2_pc : i_trap_pc;
            end
            if (i_bru_valid && i_bru_taken && shadow_ctr[i_bru_index] != 2'b11)
                shadow_ctr[i_bru_index] = shadow_ctr[i_bru_index] + 2'd1;
            else if (i_bru_valid && !i_bru_taken && shadow_ctr[i_bru_index] != 2'b00)
                shadow_ctr[i_bru_index] = shadow_ctr[i_bru_index] - 2'd1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic redirect_to(input logic [63:0] pc);
        @(posedge clk);
        i_dec1_redirect <= 1'b1;
        i_dec1_pc <= pc;
        @(posedge clk);
        i_dec1_redirect <= 1'b0;
    endtask

    task automatic train(input logic [3:0] idx, input logic taken);
        @(posedge clk);
        i_bru_valid <= 1'b1;
        i_bru_index <= idx;
        i_bru_taken <= taken;
        @(posedge clk);
        i_bru_valid <= 1'b0;
    endtask

    task automatic random_cycles(input int n, input bit stall, input bit redir, input bit bru);
        logic [31:0] h1;
        logic [31:0] h2;
        logic [31:0] h3;
        repeat (n) begin
            @(posedge clk);
            rnd = xorshift(rnd);
            h1 = xorshift(rnd);
            h2 = xorshift(rnd ^ 32'h5a5a);
            h3 = xorshift(rnd ^ 32'h3c3c);
            i_fetch_stall <= stall && rnd[1:0] == 2'b00;
            i_dec1_redirect <= redir && rnd[4:2] == 3'd0;
            i_dec2_redirect <= redir && rnd[7:5] == 3'd0;
            i_trap <= redir && rnd[10:8] == 3'd0;
            i_bru_valid <= bru && rnd[11];
            i_bru_taken <= rnd[12];
            i_bru_index <= rnd[16:13];
            i_dec1_pc <= {32'h0, 4'h8, h1[25:0], 2'b00};
            i_dec2_pc <= {32'h0, 4'h8, h2[25:0], 2'b00};
            i_trap_pc <= {32'h0, 4'h8, h3[25:0], 2'b00};
        end
        @(posedge clk);
        {i_fetch_stall, i_dec1_redirect, i_dec2_redirect, i_trap, i_bru_valid} <= '0;
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, err_count - err_mark);
        err_mark = err_count;
        test_count++;
    endtask

    initial begin
        {i_rst, i_fetch_stall, i_dec1_redirect, i_dec2_redirect, i_trap} = 5'b10000;
        {i_bru_valid, i_bru_taken, i_bru_index} = '0;
        {i_dec1_pc, i_dec2_pc, i_trap_pc} = '0;
        {pkt_mode, fixed_pkt, pend_v, pend_pc} = '0;
        {err_count, err_mark, test_count, cycles} = '0;
        salt = 32'h1234_5678;
        rnd = 32'hcf89de41;
        exp_pc = RESET_PC;
        exp_cnt = 3'd4;
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;
        repeat (6) @(posedge clk);
        redirect_to(64'h8000_1008);  // start mid block
        repeat (4) @(posedge clk);
        end_test("reset_and_sequential");
        pkt_mode <= 2'd1;
        fixed_pkt <= {32'h0400_006f, NOP, NOP, 32'h0100_006f};
        redirect_to(64'h8000_3008);
        repeat (4) @(posedge clk);
        fixed_pkt <= {NOP, NOP, 32'h0082_8067, NOP};  // jalr x0, 8(x5)
        redirect_to(64'h8000_4000);
        repeat (4) @(posedge clk);
        end_test("jal_jalr");
        fixed_pkt <= {NOP, NOP, NOP, 32'h1000_0063};
        redirect_to(64'h8000_2000);
        repeat (3) @(posedge clk);
        train(4'd0, 1'b1);
        train(4'd0, 1'b1);
        redirect_to(64'h8000_2000);
        repeat (3) @(posedge clk);
        train(4'd0, 1'b0);
        train(4'd0, 1'b0);
        redirect_to(64'h8000_2000);
        repeat (3) @(posedge clk);
        end_test("branch_prediction");
        pkt_mode <= 2'd2;
        random_cycles(40, 1'b0, 1'b1, 1'b0);
        end_test("redirect_priority");
        @(posedge clk) i_fetch_stall <= 1'b1;
        @(posedge clk) {i_dec2_redirect, i_dec2_pc} <= {1'b1, 64'h8000_5000};
        @(posedge clk) {i_dec2_redirect, i_trap, i_trap_pc} <= {2'b01, 64'h8000_6004};
        @(posedge clk) i_trap <= 1'b0;
        repeat (2) @(posedge clk);
        i_fetch_stall <= 1'b0;
        random_cycles(60, 1'b1, 1'b1, 1'b0);
        end_test("stall_pending");
        salt <= 32'h0bad_f00d;
        random_cycles(400, 1'b1, 1'b1, 1'b1);
        repeat (2) @(posedge clk);
        end_test("random_run");
        err_count += dut0.u_pc_control.u_asserts.fail_count;  // assertion failures count too
        $display("tests %0d, errors %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_pc.f ====
logic/fetch_pc_pkg.sv
logic/predecode_if.sv
logic/packet_predecode.sv
logic/branch_history_table.sv
logic/jump_target_unit.sv
logic/pc_control.sv
logic/fetch_pc_top.sv
testbench/fetch_pc_asserts.sv
testbench/fetch_pc_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_pc

sources:
  - logic/fetch_pc_pkg.sv
  - logic/predecode_if.sv
  - logic/packet_predecode.sv
  - logic/branch_history_table.sv
  - logic/jump_target_unit.sv
  - logic/pc_control.sv
  - logic/fetch_pc_top.sv
  - target: test
    files:
      - testbench/fetch_pc_asserts.sv
      - testbench/fetch_pc_tb.sv
